// ==== verilog/sw_pkg.sv ====
package sw_pkg;

	localparam int PE_COUNT = 8;
	localparam int BASE_W = 2;
	localparam int SCORE_W = 10;
	localparam int PEN_W = 4;
	localparam int CNT_W = $clog2(PE_COUNT + 1);

	typedef logic [BASE_W-1:0] base_t;
	typedef logic [SCORE_W-1:0] score_t;
	typedef logic [PEN_W-1:0] pen_t;
	typedef logic [CNT_W-1:0] cnt_t;

	// base codes
	localparam base_t BASE_A = 2'd0;
	localparam base_t BASE_C = 2'd1;
	localparam base_t BASE_G = 2'd2;
	localparam base_t BASE_T = 2'd3;

	typedef struct packed {
		pen_t match;
		pen_t mismatch;
		pen_t gap;
	} score_cfg_t;

	localparam score_cfg_t CFG_RESET = '{match: 4'd2, mismatch: 4'd1, gap: 4'd1};

	// one hop of the systolic chain
	typedef struct packed {
		base_t  base;
		logic   valid;
		score_t score;
		logic   last;
	} cell_link_t;

	typedef enum logic [1:0] {LOAD, STREAM, DRAIN, REPORT} feed_state_t;

endpackage

// ==== verilog/sw_score_config.sv ====
`timescale 1ns/10ps

module sw_score_config (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               i_cfg_valid,
	input  sw_pkg::score_cfg_t i_cfg_data,
	output logic               o_cfg_ready,
	input  logic               i_busy,
	output sw_pkg::score_cfg_t o_cfg
);

	sw_pkg::score_cfg_t cfg_q;
	logic               cfg_we;

	// new values only land between jobs
	assign o_cfg_ready = !i_busy;
	assign cfg_we = i_cfg_valid && o_cfg_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cfg_q <= sw_pkg::CFG_RESET;
		end else if (cfg_we) begin
			cfg_q <= i_cfg_data;
		end
	end

	// every cell sees the same set for the whole job
	assign o_cfg = cfg_q;

endmodule

// ==== verilog/sw_stream_feeder.sv ====
`timescale 1ns/10ps

module sw_stream_feeder (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        i_q_valid,
	input  sw_pkg::base_t               i_q_base,
	input  logic                        i_q_last,
	output logic                        o_q_ready,
	input  logic                        i_t_valid,
	input  sw_pkg::base_t               i_t_base,
	input  logic                        i_t_last,
	output logic                        o_t_ready,
	output logic                        o_busy,
	output logic                        o_load,
	output sw_pkg::base_t               o_load_base,
	output logic [sw_pkg::PE_COUNT-1:0] o_cell_en,
	output logic                        o_clear,
	output sw_pkg::cell_link_t          o_link,
	input  sw_pkg::score_t              i_best,
	output logic                        o_res_valid,
	output sw_pkg::score_t              o_res_score,
	input  logic                        i_res_ready
);

	sw_pkg::feed_state_t state;
	sw_pkg::cnt_t        q_cnt;
	sw_pkg::cnt_t        drain_cnt;
	logic                settle;
	logic                q_fire;
	logic                t_fire;
	logic                q_full;

	assign o_q_ready = (state == sw_pkg::LOAD);
	assign o_t_ready = (state == sw_pkg::STREAM);
	assign o_busy = (state != sw_pkg::LOAD);
	assign q_fire = i_q_valid && o_q_ready;
	assign t_fire = i_t_valid && o_t_ready;
	assign q_full = (q_cnt == sw_pkg::cnt_t'(sw_pkg::PE_COUNT));

	// one enable per loaded query base
	always_comb begin
		for (int i = 0; i < sw_pkg::PE_COUNT; i++) begin
			o_cell_en[i] = (q_cnt > sw_pkg::cnt_t'(i));
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= sw_pkg::LOAD;
			q_cnt <= '0;
			drain_cnt <= '0;
			settle <= 1'b0;
			o_load <= 1'b0;
			o_clear <= 1'b0;
			o_link <= '{base: sw_pkg::BASE_A, valid: 1'b0, score: '0, last: 1'b0};
			o_res_valid <= 1'b0;
		end else begin
			// bases past the array length are taken and dropped
			o_load <= q_fire && !q_full;
			o_clear <= 1'b0;
			o_link <= '{base: i_t_base, valid: t_fire, score: '0, last: t_fire && i_t_last};
			case (state)
				sw_pkg::LOAD: begin
					if (q_fire) begin
						if (!q_full) begin
							q_cnt <= q_cnt + 1'b1;
						end
						if (i_q_last) begin
							state <= sw_pkg::STREAM;
						end
					end
				end
				sw_pkg::STREAM: begin
					if (t_fire && i_t_last) begin
						state <= sw_pkg::DRAIN;
						drain_cnt <= '0;
					end
				end
				sw_pkg::DRAIN: begin
					drain_cnt <= drain_cnt + 1'b1;
					if (drain_cnt == sw_pkg::cnt_t'(sw_pkg::PE_COUNT - 1)) begin
						state <= sw_pkg::REPORT;
						settle <= 1'b0;
					end
				end
				sw_pkg::REPORT: begin
					// array max register needs one more cycle after the drain
					if (!settle) begin
						settle <= 1'b1;
					end else if (!o_res_valid) begin
						o_res_valid <= 1'b1;
					end else if (i_res_ready) begin
						o_res_valid <= 1'b0;
						settle <= 1'b0;
						q_cnt <= '0;
						o_clear <= 1'b1;
						state <= sw_pkg::LOAD;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (q_fire) begin
			o_load_base <= i_q_base;
		end
		if (state == sw_pkg::REPORT && settle && !o_res_valid) begin
			o_res_score <= i_best;
		end
	end

endmodule

// ==== verilog/sw_cell.sv ====
`timescale 1ns/10ps

module sw_cell (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               i_clear,
	input  logic               i_en,
	input  logic               i_load,
	input  sw_pkg::base_t      i_load_base,
	output sw_pkg::base_t      o_load_base,
	input  sw_pkg::score_cfg_t i_cfg,
	input  sw_pkg::cell_link_t i_link,
	output sw_pkg::cell_link_t o_link,
	output sw_pkg::score_t     o_max
);

	sw_pkg::base_t  q_base;
	sw_pkg::score_t h_left;
	sw_pkg::score_t h_diag;
	sw_pkg::score_t h_max;
	sw_pkg::score_t h_new;

	function automatic sw_pkg::score_t sub_clamp(sw_pkg::score_t a, sw_pkg::pen_t b);
		sw_pkg::score_t bx;
		bx = sw_pkg::score_t'(b);
		return (a > bx) ? a - bx : '0;
	endfunction

	// zero floor comes from the clamped subtractions
	always_comb begin
		sw_pkg::score_t diag;
		sw_pkg::score_t up;
		sw_pkg::score_t left;
		if (i_link.base == q_base) begin
			diag = h_diag + sw_pkg::score_t'(i_cfg.match);
		end else begin
			diag = sub_clamp(h_diag, i_cfg.mismatch);
		end
		up = sub_clamp(i_link.score, i_cfg.gap);
		left = sub_clamp(h_left, i_cfg.gap);
		h_new = diag;
		if (up > h_new) begin
			h_new = up;
		end
		if (left > h_new) begin
			h_new = left;
		end
	end

	always_ff @(posedge clk) begin
		if (i_load) begin
			q_base <= i_load_base;
		end
	end

	assign o_load_base = q_base;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			h_left <= '0;
			h_diag <= '0;
			h_max <= '0;
			o_link <= '0;
		end else if (i_clear) begin
			h_left <= '0;
			h_diag <= '0;
			h_max <= '0;
			o_link <= '0;
		end else begin
			// disabled cells and bubbles just pass the link on
			o_link <= i_link;
			if (i_en && i_link.valid) begin
				o_link.score <= h_new;
				h_left <= h_new;
				h_diag <= i_link.score;
				if (h_new > h_max) begin
					h_max <= h_new;
				end
			end
		end
	end

	assign o_max = i_en ? h_max : '0;

endmodule

// ==== verilog/sw_cell_array.sv ====
`timescale 1ns/10ps

module sw_cell_array (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        i_clear,
	input  logic [sw_pkg::PE_COUNT-1:0] i_cell_en,
	input  logic                        i_load,
	input  sw_pkg::base_t               i_load_base,
	input  sw_pkg::score_cfg_t          i_cfg,
	input  sw_pkg::cell_link_t          i_link,
	output sw_pkg::score_t              o_best
);

	sw_pkg::base_t      load_chain [sw_pkg::PE_COUNT+1];
	sw_pkg::cell_link_t link_chain [sw_pkg::PE_COUNT+1];
	sw_pkg::score_t     cell_max [sw_pkg::PE_COUNT];
	sw_pkg::score_t     max_all;

	// cell 0 meets each target base first but holds the last query base,
	// so the query is sent back to front
	assign load_chain[0] = i_load_base;
	assign link_chain[0] = i_link;

	for (genvar gi = 0; gi < sw_pkg::PE_COUNT; gi++) begin : g_cell
		sw_cell cell_inst (
			.clk         (clk),
			.rst_n       (rst_n),
			.i_clear     (i_clear),
			.i_en        (i_cell_en[gi]),
			.i_load      (i_load),
			.i_load_base (load_chain[gi]),
			.o_load_base (load_chain[gi+1]),
			.i_cfg       (i_cfg),
			.i_link      (link_chain[gi]),
			.o_link      (link_chain[gi+1]),
			.o_max       (cell_max[gi])
		);
	end

	always_comb begin
		max_all = '0;
		for (int i = 0; i < sw_pkg::PE_COUNT; i++) begin
			if (cell_max[i] > max_all) begin
				max_all = cell_max[i];
			end
		end
	end

	// final target base leaving the chain means every cell is done
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_best <= '0;
		end else if (i_clear) begin
			o_best <= '0;
		end else if (link_chain[sw_pkg::PE_COUNT].valid && link_chain[sw_pkg::PE_COUNT].last) begin
			o_best <= max_all;
		end
	end

endmodule

// ==== verilog/sw_aligner_top.sv ====
`timescale 1ns/10ps

module sw_aligner_top (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               i_cfg_valid,
	input  sw_pkg::score_cfg_t i_cfg_data,
	output logic               o_cfg_ready,
	input  logic               i_q_valid,
	input  sw_pkg::base_t      i_q_base,
	input  logic               i_q_last,
	output logic               o_q_ready,
	input  logic               i_t_valid,
	input  sw_pkg::base_t      i_t_base,
	input  logic               i_t_last,
	output logic               o_t_ready,
	output logic               o_res_valid,
	output sw_pkg::score_t     o_res_score,
	input  logic               i_res_ready
);

	logic                        busy;
	sw_pkg::score_cfg_t          cfg;
	logic                        load;
	sw_pkg::base_t               load_base;
	logic [sw_pkg::PE_COUNT-1:0] cell_en;
	logic                        clear;
	sw_pkg::cell_link_t          link;
	sw_pkg::score_t              best;

	sw_score_config cfg_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_cfg_valid (i_cfg_valid),
		.i_cfg_data  (i_cfg_data),
		.o_cfg_ready (o_cfg_ready),
		.i_busy      (busy),
		.o_cfg       (cfg)
	);

	sw_stream_feeder feeder_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_q_valid   (i_q_valid),
		.i_q_base    (i_q_base),
		.i_q_last    (i_q_last),
		.o_q_ready   (o_q_ready),
		.i_t_valid   (i_t_valid),
		.i_t_base    (i_t_base),
		.i_t_last    (i_t_last),
		.o_t_ready   (o_t_ready),
		.o_busy      (busy),
		.o_load      (load),
		.o_load_base (load_base),
		.o_cell_en   (cell_en),
		.o_clear     (clear),
		.o_link      (link),
		.i_best      (best),
		.o_res_valid (o_res_valid),
		.o_res_score (o_res_score),
		.i_res_ready (i_res_ready)
	);

	sw_cell_array array_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_clear     (clear),
		.i_cell_en   (cell_en),
		.i_load      (load),
		.i_load_base (load_base),
		.i_cfg       (cfg),
		.i_link      (link),
		.o_best      (best)
	);

endmodule

// ==== bench/sw_score_checker.sv ====
`timescale 1ns/10ps

module sw_score_checker (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           i_cfg_valid,
	input  logic           i_cfg_ready,
	input  logic           i_q_valid,
	input  logic           i_q_ready,
	input  logic           i_q_last,
	input  logic           i_t_ready,
	input  logic           i_res_valid,
	input  sw_pkg::score_t i_res_score,
	input  logic           i_res_ready,
	input  logic           i_exp_push,
	input  sw_pkg::score_t i_exp_score,
	input  int             i_exp_job,
	output int             o_error_count,
	output int             o_check_count
);

	int             errors = 0;
	int             checks = 0;
	logic           after_reset = 1'b0;
	logic           stalled = 1'b0;
	logic           job_busy = 1'b0;
	sw_pkg::score_t held_score = '0;
	sw_pkg::score_t exp_q[$];
	int             job_q[$];

	assign o_error_count = errors;
	assign o_check_count = checks;

	task automatic compare_score(input sw_pkg::score_t actual);
		sw_pkg::score_t expected;
		int             job;
		expected = exp_q.pop_front();
		job = job_q.pop_front();
		checks++;
		if (actual !== expected) begin
			$display("Error: job%0d expected %0d actual %0d", job, expected, actual);
			errors++;
		end
	endtask

	// sampled mid-cycle where inputs and outputs are settled
	always @(negedge clk) begin
		if (!rst_n) begin
			after_reset = 1'b1;
			stalled = 1'b0;
			job_busy = 1'b0;
		end else begin
			if (after_reset) begin
				if (i_res_valid || i_t_ready || !i_q_ready || !i_cfg_ready) begin
					$display("handshake outputs were not idle right after reset");
					errors++;
				end
				after_reset = 1'b0;
			end
			if (i_exp_push) begin
				exp_q.push_back(i_exp_score);
				job_q.push_back(i_exp_job);
			end
			// a job runs from its last query base until its result is taken
			if (i_cfg_valid && i_cfg_ready && job_busy) begin
				$display("a config write was accepted while a job was running");
				errors++;
			end
			if (i_q_valid && i_q_ready && i_q_last) begin
				job_busy = 1'b1;
			end
			if (stalled && (!i_res_valid || i_res_score !== held_score)) begin
				$display("the result changed while it was waiting for ready");
				errors++;
			end
			if (i_res_valid && i_res_ready) begin
				if (exp_q.size() == 0) begin
					$display("result %0d arrived with no job waiting for it", i_res_score);
					errors++;
				end else begin
					compare_score(i_res_score);
				end
				job_busy = 1'b0;
			end
			stalled = i_res_valid && !i_res_ready;
			held_score = i_res_score;
		end
	end

endmodule

// ==== bench/sw_aligner_tb.sv ====
`timescale 1ns/10ps

module sw_aligner_tb;

	localparam int MEM_DEPTH = 256;

	logic               clk = 1'b0;
	logic               rst_n;
	logic               i_cfg_valid;
	sw_pkg::score_cfg_t i_cfg_data;
	logic               o_cfg_ready;
	logic               i_q_valid;
	sw_pkg::base_t      i_q_base;
	logic               i_q_last;
	logic               o_q_ready;
	logic               i_t_valid;
	sw_pkg::base_t      i_t_base;
	logic               i_t_last;
	logic               o_t_ready;
	logic               o_res_valid;
	sw_pkg::score_t     o_res_score;
	logic               i_res_ready;

	logic               exp_push;
	sw_pkg::score_t     exp_score;
	int                 exp_job;
	int                 error_count;
	int                 check_count;

	logic [11:0]        pat [MEM_DEPTH];
	int                 job_count;
	int                 limit_cycles = 0;
	logic [31:0]        stim_rs;
	logic [31:0]        res_rs;

	always #10 clk = ~clk;

	sw_aligner_top sw_aligner_top_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_cfg_valid (i_cfg_valid),
		.i_cfg_data  (i_cfg_data),
		.o_cfg_ready (o_cfg_ready),
		.i_q_valid   (i_q_valid),
		.i_q_base    (i_q_base),
		.i_q_last    (i_q_last),
		.o_q_ready   (o_q_ready),
		.i_t_valid   (i_t_valid),
		.i_t_base    (i_t_base),
		.i_t_last    (i_t_last),
		.o_t_ready   (o_t_ready),
		.o_res_valid (o_res_valid),
		.o_res_score (o_res_score),
		.i_res_ready (i_res_ready)
	);

	sw_score_checker checker_inst (
		.clk           (clk),
		.rst_n         (rst_n),
		.i_cfg_valid   (i_cfg_valid),
		.i_cfg_ready   (o_cfg_ready),
		.i_q_valid     (i_q_valid),
		.i_q_ready     (o_q_ready),
		.i_q_last      (i_q_last),
		.i_t_ready     (o_t_ready),
		.i_res_valid   (o_res_valid),
		.i_res_score   (o_res_score),
		.i_res_ready   (i_res_ready),
		.i_exp_push    (exp_push),
		.i_exp_score   (exp_score),
		.i_exp_job     (exp_job),
		.o_error_count (error_count),
		.o_check_count (check_count)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// about one beat in four gets a gap in front of it
	task automatic idle_cycles();
		stim_rs = xorshift32(stim_rs);
		while (stim_rs[1:0] == 2'd0) begin
			@(posedge clk);
			#2;
			stim_rs = xorshift32(stim_rs);
		end
	endtask

	// cell 0 keeps the last base loaded, so the query goes in back to front
	task automatic send_query(input int start, input int len);
		logic ready_seen;
		for (int i = len - 1; i >= 0; i--) begin
			i_q_valid = 1'b0;
			idle_cycles();
			i_q_valid = 1'b1;
			i_q_base = sw_pkg::base_t'(pat[start + i]);
			i_q_last = (i == 0);
			do begin
				ready_seen = o_q_ready;
				@(posedge clk);
				#2;
			end while (!ready_seen);
		end
		i_q_valid = 1'b0;
		i_q_last = 1'b0;
	endtask

	task automatic send_target(input int start, input int len);
		logic ready_seen;
		for (int i = 0; i < len; i++) begin
			i_t_valid = 1'b0;
			idle_cycles();
			i_t_valid = 1'b1;
			i_t_base = sw_pkg::base_t'(pat[start + i]);
			i_t_last = (i == len - 1);
			do begin
				ready_seen = o_t_ready;
				@(posedge clk);
				#2;
			end while (!ready_seen);
		end
		i_t_valid = 1'b0;
		i_t_last = 1'b0;
	endtask

	task automatic take_result();
		logic done;
		do begin
			res_rs = xorshift32(res_rs);
			i_res_ready = (res_rs[1:0] != 2'd0);
			done = o_res_valid && i_res_ready;
			@(posedge clk);
			#2;
		end while (!done);
		i_res_ready = 1'b0;
	endtask

	task automatic write_config(input logic [11:0] cfg);
		logic ready_seen;
		i_cfg_valid = 1'b1;
		i_cfg_data = sw_pkg::score_cfg_t'(cfg);
		do begin
			ready_seen = o_cfg_ready;
			@(posedge clk);
			#2;
		end while (!ready_seen);
		i_cfg_valid = 1'b0;
	endtask

	// next job's values are offered while the current one still runs
	task automatic write_config_when_busy(input logic [11:0] cfg);
		while (o_q_ready) begin
			@(posedge clk);
			#2;
		end
		write_config(cfg);
	endtask

	initial begin
		int idx;
		int qlen;
		int tlen;
		int total;
		rst_n = 1'b0;
		i_cfg_valid = 1'b0;
		i_cfg_data = '0;
		i_q_valid = 1'b0;
		i_q_base = '0;
		i_q_last = 1'b0;
		i_t_valid = 1'b0;
		i_t_base = '0;
		i_t_last = 1'b0;
		i_res_ready = 1'b0;
		exp_push = 1'b0;
		exp_score = '0;
		exp_job = 0;
		stim_rs = 32'd1913;
		res_rs = xorshift32(32'd1913);
		$readmemh("bench/sw_patterns.hex", pat);
		job_count = int'(pat[0]);
		idx = 1;
		total = 10;
		for (int j = 0; j < job_count; j++) begin
			qlen = int'(pat[idx + 1]);
			tlen = int'(pat[idx + 2 + qlen]);
			total += (qlen + tlen + sw_pkg::PE_COUNT + 50) * 4;
			idx += qlen + tlen + 4;
		end
		limit_cycles = total;
		repeat (10) @(posedge clk);
		#2;
		rst_n = 1'b1;
		repeat (2) @(posedge clk);
		#2;
		write_config(pat[1]);
		idx = 1;
		for (int j = 0; j < job_count; j++) begin
			qlen = int'(pat[idx + 1]);
			tlen = int'(pat[idx + 2 + qlen]);
			exp_push = 1'b1;
			exp_job = j;
			exp_score = sw_pkg::score_t'(pat[idx + 3 + qlen + tlen]);
			@(posedge clk);
			#2;
			exp_push = 1'b0;
			fork
				begin
					send_query(idx + 2, qlen);
					send_target(idx + 3 + qlen, tlen);
				end
				take_result();
				begin
					if (j + 1 < job_count) begin
						write_config_when_busy(pat[idx + 4 + qlen + tlen]);
					end
				end
			join
			idx += qlen + tlen + 4;
		end
		if (check_count != job_count) begin
			$display("only %0d of %0d jobs returned a result", check_count, job_count);
		end
		$display("errors: %0d, results checked: %0d of %0d", error_count, check_count, job_count);
		if (error_count == 0 && check_count == job_count) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("timeout: the jobs did not finish within %0d cycles", limit_cycles);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== bench/sw_patterns.hex ====
// first word is the job count, then one job per line
// cfg (match mismatch gap), qlen, query, tlen, target, expected score; A=0 C=1 G=2 T=3
6
// exact match, default scoring
211 4 0 1 2 3 8 3 3 0 1 2 3 0 0 008
// full array, exact match with new scoring
312 8 2 0 3 3 0 1 0 2 a 1 2 0 3 3 0 1 0 2 3 018
// one mismatch
211 4 0 1 2 3 4 0 1 3 3 005
// short query, nothing matches
211 2 0 0 5 1 2 3 2 1 000
// one gap in the query
221 4 0 1 2 3 5 0 1 2 2 3 007
312 4 2 2 0 1 5 2 3 0 1 1 008

// ==== sources.f ====
verilog/sw_pkg.sv
verilog/sw_score_config.sv
verilog/sw_stream_feeder.sv
verilog/sw_cell.sv
verilog/sw_cell_array.sv
verilog/sw_aligner_top.sv
bench/sw_score_checker.sv
bench/sw_aligner_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    := --binary --timing -Wno-fatal
TOP       := sw_aligner_tb
FILELIST  := sources.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
